//--- hw/tg_cfg_pkg.sv
package tg_cfg_pkg;

  // traffic pattern select, unknown codes fall back to random
  typedef enum logic [2:0] {
    PAT_RANDOM     = 3'd0,
    PAT_COMPLEMENT = 3'd1,
    PAT_TRANSPOSE  = 3'd2,
    PAT_NEIGHBOR   = 3'd3,
    PAT_TORNADO    = 3'd4
  } pattern_e;

  // random word width
  localparam int RAND_W = 32;

  // transaction id width
  localparam int TXN_W = 16;

  // statistics counter width
  localparam int STAT_W = 32;

  // lfsr state out of reset, must be nonzero
  localparam logic [RAND_W-1:0] LFSR_RESET_SEED = 32'h0000_0001;

endpackage

//--- hw/tg_noc_pkg.sv
package tg_noc_pkg;

  // node position along x or y, mesh up to 4 x 4
  typedef logic [1:0] coord_t;

  // local port number, up to 2 per node
  typedef logic [0:0] port_t;

  // look-ahead output direction of the first hop
  typedef enum logic [2:0] {
    DIR_N = 3'd0,
    DIR_S = 3'd1,
    DIR_E = 3'd2,
    DIR_W = 3'd3,
    DIR_L = 3'd4 // eject at target router
  } dir_e;

endpackage

//--- hw/tg_lfsr.sv
`timescale 1ns/1ns

module tg_lfsr (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          en_i,
  input  logic                          load_i,
  input  logic [tg_cfg_pkg::RAND_W-1:0] seed_i,
  output logic [tg_cfg_pkg::RAND_W-1:0] word_o
);

  logic [tg_cfg_pkg::RAND_W-1:0] lfsr_q;
  logic                          fb;

  // taps 32, 22, 2, 1
  assign fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lfsr_q <= tg_cfg_pkg::LFSR_RESET_SEED;
    end else if (load_i) begin // seed wins over stepping
      lfsr_q <= seed_i;
    end else if (en_i) begin
      lfsr_q <= {lfsr_q[tg_cfg_pkg::RAND_W-2:0], fb};
    end
  end

  assign word_o = lfsr_q;

  // the all-zero state locks up, so a zero seed must never be loaded
  a_lfsr_nonzero: assert property (
    @(posedge clk) disable iff (!rstn)
    load_i |=> (lfsr_q != '0)
  ) else $error("lfsr loaded with zero seed");

endmodule

//--- hw/tg_pattern_gen.sv
`timescale 1ns/1ns

module tg_pattern_gen #(
  parameter int MESH_X      = 4,
  parameter int MESH_Y      = 4,
  parameter int LOCAL_PORTS = 2
) (
  input  tg_cfg_pkg::pattern_e          pattern_i,
  input  logic [tg_cfg_pkg::RAND_W-1:0] src_word_i,
  input  logic [tg_cfg_pkg::RAND_W-1:0] tgt_word_i,
  output tg_noc_pkg::coord_t            src_x_o,
  output tg_noc_pkg::coord_t            src_y_o,
  output tg_noc_pkg::coord_t            tgt_x_o,
  output tg_noc_pkg::coord_t            tgt_y_o,
  output tg_noc_pkg::port_t             src_port_o,
  output tg_noc_pkg::port_t             tgt_port_o,
  output tg_noc_pkg::dir_e              route_o,
  output logic                          cand_vld_o
);

  localparam int TOP = tg_cfg_pkg::RAND_W - 1;
  localparam int TORNADO_OFS = (MESH_X + 1) / 2 - 1; // ceil(x/2) - 1

  tg_noc_pkg::coord_t src_x;
  tg_noc_pkg::coord_t src_y;
  tg_noc_pkg::coord_t tgt_x;
  tg_noc_pkg::coord_t tgt_y;

  // source position and both ports do not depend on the pattern
  assign src_x = tg_noc_pkg::coord_t'(src_word_i[2:0] % MESH_X);
  assign src_y = tg_noc_pkg::coord_t'(src_word_i[TOP -: 3] % MESH_Y);

  assign src_port_o = tg_noc_pkg::port_t'((src_word_i[1:0] ^ tgt_word_i[TOP -: 2]) % LOCAL_PORTS);
  assign tgt_port_o = tg_noc_pkg::port_t'((src_word_i[TOP -: 2] ^ tgt_word_i[1:0]) % LOCAL_PORTS);

  always_comb begin
    case (pattern_i)
      tg_cfg_pkg::PAT_COMPLEMENT: begin
        tgt_x = tg_noc_pkg::coord_t'(MESH_X - 1 - int'(src_x));
        tgt_y = tg_noc_pkg::coord_t'(MESH_Y - 1 - int'(src_y));
      end
      tg_cfg_pkg::PAT_TRANSPOSE: begin
        tgt_x = tg_noc_pkg::coord_t'(int'(src_y) % MESH_X);
        tgt_y = tg_noc_pkg::coord_t'(int'(src_x) % MESH_Y);
      end
      tg_cfg_pkg::PAT_NEIGHBOR: begin
        tgt_x = tg_noc_pkg::coord_t'((int'(src_x) + 1) % MESH_X);
        tgt_y = src_y;
      end
      tg_cfg_pkg::PAT_TORNADO: begin
        tgt_x = tg_noc_pkg::coord_t'((int'(src_x) + TORNADO_OFS) % MESH_X);
        tgt_y = src_y;
      end
      default: begin // random and unused codes
        tgt_x = tg_noc_pkg::coord_t'(tgt_word_i[2:0] % MESH_X);
        tgt_y = tg_noc_pkg::coord_t'(tgt_word_i[TOP -: 3] % MESH_Y);
      end
    endcase
  end

  // xy order, x first
  always_comb begin
    if (tgt_x > src_x) begin
      route_o = tg_noc_pkg::DIR_E;
    end else if (tgt_x < src_x) begin
      route_o = tg_noc_pkg::DIR_W;
    end else if (tgt_y > src_y) begin
      route_o = tg_noc_pkg::DIR_N;
    end else if (tgt_y < src_y) begin
      route_o = tg_noc_pkg::DIR_S;
    end else begin
      route_o = tg_noc_pkg::DIR_L;
    end
  end

  assign cand_vld_o = (src_x != tgt_x) || (src_y != tgt_y); // no same-router tests

  assign src_x_o = src_x;
  assign src_y_o = src_y;
  assign tgt_x_o = tgt_x;
  assign tgt_y_o = tgt_y;

  always_comb begin
    a_coord_in_mesh: assert ((int'(src_x) < MESH_X) && (int'(tgt_x) < MESH_X) &&
                             (int'(src_y) < MESH_Y) && (int'(tgt_y) < MESH_Y))
      else $error("pattern coordinate outside mesh");
  end

endmodule

//--- hw/tg_credit_dispatch.sv
`timescale 1ns/1ns

module tg_credit_dispatch #(
  parameter int MESH_X      = 4,
  parameter int MESH_Y      = 4,
  parameter int LOCAL_PORTS = 2,
  parameter int SENDER_NUM  = MESH_X * MESH_Y * LOCAL_PORTS,
  parameter int CREDIT_NUM  = 2,
  localparam int IDX_W      = (SENDER_NUM > 1) ? $clog2(SENDER_NUM) : 1
) (
  input  logic                         clk,
  input  logic                         rstn,
  input  tg_noc_pkg::coord_t           cand_src_x_i,
  input  tg_noc_pkg::coord_t           cand_src_y_i,
  input  tg_noc_pkg::port_t            cand_src_port_i,
  input  tg_noc_pkg::coord_t           cand_tgt_x_i,
  input  tg_noc_pkg::coord_t           cand_tgt_y_i,
  input  tg_noc_pkg::port_t            cand_tgt_port_i,
  input  tg_noc_pkg::dir_e             cand_route_i,
  input  logic                         cand_vld_i,
  input  logic [SENDER_NUM-1:0]        credit_return_i,
  output logic [SENDER_NUM-1:0]        test_vld_o,
  output tg_noc_pkg::coord_t           test_tgt_x_o,
  output tg_noc_pkg::coord_t           test_tgt_y_o,
  output tg_noc_pkg::port_t            test_tgt_port_o,
  output tg_noc_pkg::dir_e             test_route_o,
  output logic [tg_cfg_pkg::TXN_W-1:0] test_txn_id_o,
  output logic                         gen_pulse_o,
  output logic                         sent_pulse_o,
  output logic [IDX_W-1:0]             sent_idx_o
);

  localparam int CRD_W = $clog2(CREDIT_NUM + 1);

  logic [IDX_W-1:0]             idx_d;
  logic [IDX_W-1:0]             idx_q;
  logic                         vld_q;
  tg_noc_pkg::coord_t           tgt_x_q;
  tg_noc_pkg::coord_t           tgt_y_q;
  tg_noc_pkg::port_t            tgt_port_q;
  tg_noc_pkg::dir_e             route_q;
  logic [tg_cfg_pkg::TXN_W-1:0] txn_q;
  logic [CRD_W-1:0]             credit_q [SENDER_NUM];
  logic [SENDER_NUM-1:0]        crd_full;
  logic                         issue;

  // sender id = (x * MESH_Y + y) * LOCAL_PORTS + port
  assign idx_d = IDX_W'((int'(cand_src_x_i) * MESH_Y + int'(cand_src_y_i)) * LOCAL_PORTS +
                        int'(cand_src_port_i));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= cand_vld_i; // refilled every cycle, never stalls
    end
  end

  always_ff @(posedge clk) begin
    idx_q      <= idx_d;
    tgt_x_q    <= cand_tgt_x_i;
    tgt_y_q    <= cand_tgt_y_i;
    tgt_port_q <= cand_tgt_port_i;
    route_q    <= cand_route_i;
  end

  assign issue = vld_q && (credit_q[idx_q] != '0); // otherwise dropped

  always_comb begin
    test_vld_o = '0;
    if (issue) begin
      test_vld_o[idx_q] = 1'b1;
    end
  end

  for (genvar s = 0; s < SENDER_NUM; s++) begin : g_credit
    always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
        credit_q[s] <= CRD_W'(CREDIT_NUM);
      end else if (test_vld_o[s] && !credit_return_i[s]) begin
        credit_q[s] <= credit_q[s] - 1'b1;
      end else if (!test_vld_o[s] && credit_return_i[s]) begin
        credit_q[s] <= credit_q[s] + 1'b1;
      end
    end

    assign crd_full[s] = (credit_q[s] == CRD_W'(CREDIT_NUM));
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      txn_q <= '0;
    end else if (issue) begin
      txn_q <= txn_q + 1'b1;
    end
  end

  assign test_tgt_x_o    = tgt_x_q;
  assign test_tgt_y_o    = tgt_y_q;
  assign test_tgt_port_o = tgt_port_q;
  assign test_route_o    = route_q;
  assign test_txn_id_o   = txn_q;

  assign gen_pulse_o  = vld_q;
  assign sent_pulse_o = issue;
  assign sent_idx_o   = idx_q;

  a_vld_onehot: assert property (
    @(posedge clk) disable iff (!rstn)
    $onehot0(test_vld_o)
  ) else $error("more than one sender selected");

  // receivers only hand back credits for tests they took
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rstn)
    (credit_return_i & crd_full) == '0
  ) else $error("credit returned to full counter");

endmodule

//--- hw/tg_traffic_stats.sv
`timescale 1ns/1ns

module tg_traffic_stats #(
  parameter int SENDER_NUM = 32,
  localparam int IDX_W     = (SENDER_NUM > 1) ? $clog2(SENDER_NUM) : 1
) (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          gen_pulse_i,
  input  logic                          sent_pulse_i,
  input  logic [IDX_W-1:0]              sent_idx_i,
  input  logic [IDX_W-1:0]              stat_sel_i,
  output logic [tg_cfg_pkg::STAT_W-1:0] gen_total_o,
  output logic [tg_cfg_pkg::STAT_W-1:0] sent_total_o,
  output logic [tg_cfg_pkg::STAT_W-1:0] stat_sent_o
);

  logic [tg_cfg_pkg::STAT_W-1:0] gen_total_q;
  logic [tg_cfg_pkg::STAT_W-1:0] sent_total_q;
  logic [tg_cfg_pkg::STAT_W-1:0] sent_cnt_q [SENDER_NUM];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      gen_total_q  <= '0;
      sent_total_q <= '0;
    end else begin
      if (gen_pulse_i) begin
        gen_total_q <= gen_total_q + 1'b1; // dropped tests count too
      end
      if (sent_pulse_i) begin
        sent_total_q <= sent_total_q + 1'b1;
      end
    end
  end

  for (genvar s = 0; s < SENDER_NUM; s++) begin : g_sent_cnt
    always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
        sent_cnt_q[s] <= '0;
      end else if (sent_pulse_i && (sent_idx_i == IDX_W'(s))) begin
        sent_cnt_q[s] <= sent_cnt_q[s] + 1'b1;
      end
    end
  end

  assign gen_total_o  = gen_total_q;
  assign sent_total_o = sent_total_q;
  assign stat_sent_o  = (int'(stat_sel_i) < SENDER_NUM) ? sent_cnt_q[stat_sel_i] : '0;

  a_sent_le_gen: assert property (
    @(posedge clk) disable iff (!rstn)
    sent_total_q <= gen_total_q
  ) else $error("sent total above generated total");

endmodule

//--- hw/tg_traffic_gen_top.sv
`timescale 1ns/1ns

module tg_traffic_gen_top #(
  parameter int MESH_X      = 4,
  parameter int MESH_Y      = 4,
  parameter int LOCAL_PORTS = 2,
  parameter int SENDER_NUM  = MESH_X * MESH_Y * LOCAL_PORTS,
  parameter int CREDIT_NUM  = 2,
  localparam int IDX_W      = (SENDER_NUM > 1) ? $clog2(SENDER_NUM) : 1
) (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          run_i,
  input  logic                          seed_load_i,
  input  logic [tg_cfg_pkg::RAND_W-1:0] seed_src_i,
  input  logic [tg_cfg_pkg::RAND_W-1:0] seed_tgt_i,
  input  tg_cfg_pkg::pattern_e          pattern_i,
  input  logic [SENDER_NUM-1:0]         credit_return_i,
  input  logic [IDX_W-1:0]              stat_sel_i,
  output logic [SENDER_NUM-1:0]         test_vld_o,
  output tg_noc_pkg::coord_t            test_tgt_x_o,
  output tg_noc_pkg::coord_t            test_tgt_y_o,
  output tg_noc_pkg::port_t             test_tgt_port_o,
  output tg_noc_pkg::dir_e              test_route_o,
  output logic [tg_cfg_pkg::TXN_W-1:0]  test_txn_id_o,
  output logic [tg_cfg_pkg::STAT_W-1:0] gen_total_o,
  output logic [tg_cfg_pkg::STAT_W-1:0] sent_total_o,
  output logic [tg_cfg_pkg::STAT_W-1:0] stat_sent_o
);

  logic [tg_cfg_pkg::RAND_W-1:0] src_word;
  logic [tg_cfg_pkg::RAND_W-1:0] tgt_word;
  tg_noc_pkg::coord_t            cand_src_x;
  tg_noc_pkg::coord_t            cand_src_y;
  tg_noc_pkg::coord_t            cand_tgt_x;
  tg_noc_pkg::coord_t            cand_tgt_y;
  tg_noc_pkg::port_t             cand_src_port;
  tg_noc_pkg::port_t             cand_tgt_port;
  tg_noc_pkg::dir_e              cand_route;
  logic                          cand_vld;
  logic                          gen_pulse;
  logic                          sent_pulse;
  logic [IDX_W-1:0]              sent_idx;

  tg_lfsr i_src_lfsr (
    .clk    (clk),
    .rstn   (rstn),
    .en_i   (run_i),
    .load_i (seed_load_i),
    .seed_i (seed_src_i),
    .word_o (src_word)
  );

  tg_lfsr i_tgt_lfsr (
    .clk    (clk),
    .rstn   (rstn),
    .en_i   (run_i),
    .load_i (seed_load_i),
    .seed_i (seed_tgt_i),
    .word_o (tgt_word)
  );

  tg_pattern_gen #(
    .MESH_X      (MESH_X),
    .MESH_Y      (MESH_Y),
    .LOCAL_PORTS (LOCAL_PORTS)
  ) i_pattern_gen (
    .pattern_i  (pattern_i),
    .src_word_i (src_word),
    .tgt_word_i (tgt_word),
    .src_x_o    (cand_src_x),
    .src_y_o    (cand_src_y),
    .tgt_x_o    (cand_tgt_x),
    .tgt_y_o    (cand_tgt_y),
    .src_port_o (cand_src_port),
    .tgt_port_o (cand_tgt_port),
    .route_o    (cand_route),
    .cand_vld_o (cand_vld)
  );

  tg_credit_dispatch #(
    .MESH_X      (MESH_X),
    .MESH_Y      (MESH_Y),
    .LOCAL_PORTS (LOCAL_PORTS),
    .SENDER_NUM  (SENDER_NUM),
    .CREDIT_NUM  (CREDIT_NUM)
  ) i_dispatch (
    .clk             (clk),
    .rstn            (rstn),
    .cand_src_x_i    (cand_src_x),
    .cand_src_y_i    (cand_src_y),
    .cand_src_port_i (cand_src_port),
    .cand_tgt_x_i    (cand_tgt_x),
    .cand_tgt_y_i    (cand_tgt_y),
    .cand_tgt_port_i (cand_tgt_port),
    .cand_route_i    (cand_route),
    .cand_vld_i      (cand_vld),
    .credit_return_i (credit_return_i),
    .test_vld_o      (test_vld_o),
    .test_tgt_x_o    (test_tgt_x_o),
    .test_tgt_y_o    (test_tgt_y_o),
    .test_tgt_port_o (test_tgt_port_o),
    .test_route_o    (test_route_o),
    .test_txn_id_o   (test_txn_id_o),
    .gen_pulse_o     (gen_pulse),
    .sent_pulse_o    (sent_pulse),
    .sent_idx_o      (sent_idx)
  );

  tg_traffic_stats #(
    .SENDER_NUM (SENDER_NUM)
  ) i_stats (
    .clk          (clk),
    .rstn         (rstn),
    .gen_pulse_i  (gen_pulse),
    .sent_pulse_i (sent_pulse),
    .sent_idx_i   (sent_idx),
    .stat_sel_i   (stat_sel_i),
    .gen_total_o  (gen_total_o),
    .sent_total_o (sent_total_o),
    .stat_sent_o  (stat_sent_o)
  );

endmodule

//--- dv/tg_tb.sv
`timescale 1ns/1ns

module tg_tb;

  localparam int MESH_X      = 4;
  localparam int MESH_Y      = 4;
  localparam int LOCAL_PORTS = 2;
  localparam int SENDER_NUM  = MESH_X * MESH_Y * LOCAL_PORTS;
  localparam int CREDIT_NUM  = 2;
  localparam int IDX_W       = $clog2(SENDER_NUM);
  localparam int ROWS        = 6;
  localparam int RESET_CYC   = 16;
  localparam int CRD_PROMPT  = 0; // return 3 cycles after receipt
  localparam int CRD_JITTER  = 1; // random return delay
  localparam int CRD_STARVED = 2; // no returns

  logic                          clk, rstn, run, seed_load;
  logic [31:0]                   seed_src, seed_tgt;
  tg_cfg_pkg::pattern_e          pattern;
  logic [SENDER_NUM-1:0]         credit_return, test_vld;
  logic [IDX_W-1:0]              stat_sel;
  tg_noc_pkg::coord_t            test_tgt_x, test_tgt_y;
  tg_noc_pkg::port_t             test_tgt_port;
  tg_noc_pkg::dir_e              test_route;
  logic [tg_cfg_pkg::TXN_W-1:0]  test_txn_id;
  logic [tg_cfg_pkg::STAT_W-1:0] gen_total, sent_total, stat_sent;

  string                row_name [ROWS];
  tg_cfg_pkg::pattern_e row_pat [ROWS];
  logic [31:0]          row_src [ROWS], row_tgt [ROWS];
  int                   row_cycles [ROWS], row_mode [ROWS];

  // reference model state
  logic [31:0]          m_src, m_tgt, lcg;
  tg_cfg_pkg::pattern_e exp_pat;
  logic                 exp_vld;
  int                   exp_idx;
  tg_noc_pkg::coord_t   exp_tx, exp_ty;
  tg_noc_pkg::port_t    exp_tp;
  tg_noc_pkg::dir_e     exp_route;
  int                   crd [SENDER_NUM], pend [SENDER_NUM], timer [SENDER_NUM];
  int                   row_rx [SENDER_NUM], sent_cnt [SENDER_NUM];
  int                   gen_model, sent_model, err_cnt, cyc, cur_mode, wd_cycles;
  string                cur_name;

  tg_traffic_gen_top i_dut (
    .clk             (clk),
    .rstn            (rstn),
    .run_i           (run),
    .seed_load_i     (seed_load),
    .seed_src_i      (seed_src),
    .seed_tgt_i      (seed_tgt),
    .pattern_i       (pattern),
    .credit_return_i (credit_return),
    .stat_sel_i      (stat_sel),
    .test_vld_o      (test_vld),
    .test_tgt_x_o    (test_tgt_x),
    .test_tgt_y_o    (test_tgt_y),
    .test_tgt_port_o (test_tgt_port),
    .test_route_o    (test_route),
    .test_txn_id_o   (test_txn_id),
    .gen_total_o     (gen_total),
    .sent_total_o    (sent_total),
    .stat_sent_o     (stat_sent)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int ret_delay();
    if (cur_mode != CRD_JITTER) return 3;
    lcg = lcg_next(lcg);
    return 1 + int'(lcg[23:16] % 8);
  endfunction

  function automatic tg_noc_pkg::dir_e xy_route(input int sx, sy, tx, ty);
    if (tx > sx) return tg_noc_pkg::DIR_E;
    if (tx < sx) return tg_noc_pkg::DIR_W;
    if (ty > sy) return tg_noc_pkg::DIR_N;
    if (ty < sy) return tg_noc_pkg::DIR_S;
    return tg_noc_pkg::DIR_L;
  endfunction

  task automatic report_err(input string what, input logic [31:0] exp, input logic [31:0] act);
    err_cnt++;
    $display("ERR %s %s: expected %0h actual %0h", cur_name, what, exp, act);
  endtask

  task automatic report_fault(input string msg);
    err_cnt++;
    $display("%s: %s", cur_name, msg);
  endtask

  task automatic add_row(input int r, input string name, input tg_cfg_pkg::pattern_e pat,
                         input logic [31:0] s_src, s_tgt, input int cycles, mode);
    row_name[r]   = name;
    row_pat[r]    = pat;
    row_src[r]    = s_src;
    row_tgt[r]    = s_tgt;
    row_cycles[r] = cycles;
    row_mode[r]   = mode;
  endtask

  // candidate the dut registers at the next edge
  task automatic form_candidate(input tg_cfg_pkg::pattern_e pat, input logic [31:0] sw, tw);
    int sx, sy, sp, tx, ty;
    sx = sw[2:0] % MESH_X;
    sy = sw[31:29] % MESH_Y;
    sp = (sw[1:0] ^ tw[31:30]) % LOCAL_PORTS;
    case (pat)
      tg_cfg_pkg::PAT_COMPLEMENT: begin
        tx = MESH_X - 1 - sx;
        ty = MESH_Y - 1 - sy;
      end
      tg_cfg_pkg::PAT_TRANSPOSE: begin
        tx = sy % MESH_X;
        ty = sx % MESH_Y;
      end
      tg_cfg_pkg::PAT_NEIGHBOR: begin
        tx = (sx + 1) % MESH_X;
        ty = sy;
      end
      tg_cfg_pkg::PAT_TORNADO: begin
        tx = (sx + (MESH_X + 1) / 2 - 1) % MESH_X;
        ty = sy;
      end
      default: begin
        tx = tw[2:0] % MESH_X;
        ty = tw[31:29] % MESH_Y;
      end
    endcase
    exp_pat   = pat;
    exp_vld   = (sx != tx) || (sy != ty);
    exp_idx   = (sx * MESH_Y + sy) * LOCAL_PORTS + sp;
    exp_tx    = 2'(tx);
    exp_ty    = 2'(ty);
    exp_tp    = 1'((sw[31:30] ^ tw[1:0]) % LOCAL_PORTS);
    exp_route = xy_route(sx, sy, tx, ty);
  endtask

  // pattern and route rules against the source decoded from the sender bit
  task automatic check_rules(input int idx);
    int sx, sy, tx, ty, rx, ry;
    sx = idx / (MESH_Y * LOCAL_PORTS);
    sy = (idx / LOCAL_PORTS) % MESH_Y;
    tx = int'(test_tgt_x);
    ty = int'(test_tgt_y);
    rx = tx; // random target is free
    ry = ty;
    case (exp_pat)
      tg_cfg_pkg::PAT_COMPLEMENT: begin
        rx = MESH_X - 1 - sx;
        ry = MESH_Y - 1 - sy;
      end
      tg_cfg_pkg::PAT_TRANSPOSE: begin
        rx = sy % MESH_X;
        ry = sx % MESH_Y;
      end
      tg_cfg_pkg::PAT_NEIGHBOR: begin
        rx = (sx + 1) % MESH_X;
        ry = sy;
      end
      tg_cfg_pkg::PAT_TORNADO: begin
        rx = (sx + (MESH_X + 1) / 2 - 1) % MESH_X;
        ry = sy;
      end
      default: ;
    endcase
    if (tx != rx) report_err("pattern tgt_x", rx, tx);
    if (ty != ry) report_err("pattern tgt_y", ry, ty);
    if (tx == sx && ty == sy) begin
      report_fault($sformatf("sender %0d got a test for its own router", idx));
    end
    if (test_route !== xy_route(sx, sy, tx, ty)) begin
      report_err("xy route", xy_route(sx, sy, tx, ty), test_route);
    end
  endtask

  // one clock: check outputs, track credits, drive the next inputs
  task automatic step(input logic load, input logic [31:0] s_src, s_tgt,
                      input tg_cfg_pkg::pattern_e pat);
    logic                  issue;
    logic [SENDER_NUM-1:0] exp_bits, ret;
    @(negedge clk);
    issue    = exp_vld && (crd[exp_idx] > 0);
    exp_bits = '0;
    if (issue) begin
      exp_bits[exp_idx] = 1'b1;
    end
    if (test_vld !== exp_bits) report_err("test_vld", exp_bits, test_vld);
    if (gen_total !== gen_model) report_err("gen_total", gen_model, gen_total);
    if (sent_total !== sent_model) report_err("sent_total", sent_model, sent_total);
    if (stat_sent !== sent_cnt[stat_sel]) report_err("stat_sent", sent_cnt[stat_sel], stat_sent);
    if (issue && test_vld[exp_idx]) begin
      if (test_tgt_x !== exp_tx) report_err("tgt_x", exp_tx, test_tgt_x);
      if (test_tgt_y !== exp_ty) report_err("tgt_y", exp_ty, test_tgt_y);
      if (test_tgt_port !== exp_tp) report_err("tgt_port", exp_tp, test_tgt_port);
      if (test_route !== exp_route) report_err("route", exp_route, test_route);
    end
    if (test_vld != '0 && test_txn_id !== 16'(sent_model)) begin
      report_err("txn_id", sent_model, test_txn_id);
    end
    if (exp_vld) gen_model++;
    ret = '0;
    for (int s = 0; s < SENDER_NUM; s++) begin
      if (test_vld[s]) begin
        check_rules(s);
        crd[s]--;
        if (crd[s] < 0) report_fault($sformatf("sender %0d took a test without credit", s));
        row_rx[s]++;
        sent_cnt[s]++;
        sent_model++;
        if (cur_mode == CRD_STARVED && row_rx[s] > CREDIT_NUM) begin
          report_fault($sformatf("sender %0d got more tests than its credits", s));
        end
      end
      if (timer[s] > 0) begin
        timer[s]--;
        if (timer[s] == 0) begin
          ret[s] = 1'b1;
          crd[s]++;
          pend[s]--;
          if (pend[s] > 0) timer[s] = ret_delay();
        end
      end
      if (test_vld[s] && cur_mode != CRD_STARVED) begin
        pend[s]++;
        if (timer[s] == 0) timer[s] = ret_delay();
      end
    end
    credit_return = ret;
    seed_load     = load;
    seed_src      = s_src;
    seed_tgt      = s_tgt;
    pattern       = pat;
    run           = 1'b1;
    stat_sel      = IDX_W'(cyc % SENDER_NUM); // sweep every sender counter
    form_candidate(pat, m_src, m_tgt);
    if (load) begin
      m_src = s_src;
      m_tgt = s_tgt;
    end else begin
      m_src = lfsr_next(m_src);
      m_tgt = lfsr_next(m_tgt);
    end
    cyc++;
  endtask

  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", wd_cycles);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int gen_start, sent_start, total;
    rstn          = 1'b0;
    run           = 1'b0;
    seed_load     = 1'b0;
    seed_src      = '0;
    seed_tgt      = '0;
    pattern       = tg_cfg_pkg::PAT_RANDOM;
    credit_return = '0;
    stat_sel      = '0;
    err_cnt       = 0;
    gen_model     = 0;
    sent_model    = 0;
    cyc           = 0;
    lcg           = 32'hbf317fb0;
    cur_name      = "reset";
    cur_mode      = CRD_PROMPT;
    exp_vld       = 1'b0;
    exp_idx       = 0;
    exp_pat       = tg_cfg_pkg::PAT_RANDOM;
    m_src         = tg_cfg_pkg::LFSR_RESET_SEED;
    m_tgt         = tg_cfg_pkg::LFSR_RESET_SEED;
    for (int s = 0; s < SENDER_NUM; s++) begin
      crd[s]      = CREDIT_NUM;
      pend[s]     = 0;
      timer[s]    = 0;
      row_rx[s]   = 0;
      sent_cnt[s] = 0;
    end
    add_row(0, "random", tg_cfg_pkg::PAT_RANDOM, 32'h1234_5678, 32'h9abc_def1, 200, CRD_PROMPT);
    add_row(1, "complement", tg_cfg_pkg::PAT_COMPLEMENT,
            32'hcafe_f00d, 32'h0bad_beef, 150, CRD_PROMPT);
    add_row(2, "transpose", tg_cfg_pkg::PAT_TRANSPOSE,
            32'h5a5a_1234, 32'ha5a5_4321, 150, CRD_JITTER);
    add_row(3, "neighbor", tg_cfg_pkg::PAT_NEIGHBOR,
            32'h0f0f_7777, 32'h3c3c_9999, 150, CRD_JITTER);
    add_row(4, "tornado", tg_cfg_pkg::PAT_TORNADO,
            32'h7654_3210, 32'hfedc_ba98, 150, CRD_PROMPT);
    add_row(5, "random_starved", tg_cfg_pkg::PAT_RANDOM,
            32'hdead_beef, 32'h1357_9bdf, 120, CRD_STARVED);
    total = RESET_CYC;
    for (int r = 0; r < ROWS; r++) begin
      total += row_cycles[r];
    end
    wd_cycles = total * 2;

    repeat (RESET_CYC) begin
      @(negedge clk);
      if (test_vld !== '0) report_fault("test_vld active during reset");
      if (gen_total !== '0 || sent_total !== '0 || stat_sent !== '0) begin
        report_fault("counters not zero during reset");
      end
    end
    rstn = 1'b1;
    form_candidate(tg_cfg_pkg::PAT_RANDOM, m_src, m_tgt); // lfsr holds, run still low

    for (int r = 0; r < ROWS; r++) begin
      cur_name   = row_name[r];
      cur_mode   = row_mode[r];
      gen_start  = gen_total;
      sent_start = sent_total;
      for (int s = 0; s < SENDER_NUM; s++) begin
        row_rx[s] = 0;
      end
      step(1'b1, row_src[r], row_tgt[r], row_pat[r]);
      for (int c = 1; c < row_cycles[r]; c++) begin
        step(1'b0, row_src[r], row_tgt[r], row_pat[r]);
      end
      if (gen_total < sent_total) report_fault("sent total above generated total");
      if (cur_mode == CRD_STARVED && (gen_total - gen_start) <= (sent_total - sent_start)) begin
        report_fault("no test was dropped while credits were starved");
      end
    end
    repeat (2) step(1'b0, row_src[ROWS-1], row_tgt[ROWS-1], row_pat[ROWS-1]);

    $display("errors: %0d, tests generated: %0d, tests sent: %0d",
             err_cnt, gen_model, sent_model);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
hw/tg_cfg_pkg.sv
hw/tg_noc_pkg.sv
hw/tg_lfsr.sv
hw/tg_pattern_gen.sv
hw/tg_credit_dispatch.sv
hw/tg_traffic_stats.sv
hw/tg_traffic_gen_top.sv
dv/tg_tb.sv

//--- Makefile
SIM_DIR = obj_dir

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tg_tb -o tg_sim

run: build
	./$(SIM_DIR)/tg_sim > sim.log 2>&1; cat sim.log
	grep -q "^TEST PASSED$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module tg_traffic_gen_top

clean:
	rm -rf $(SIM_DIR) sim.log

.PHONY: all build run lint clean
